// File: source/processorci_pkg.sv
`default_nettype none

package processorci_pkg;

    localparam int XLEN             = 32;
    localparam int MEM_WORDS        = 256;
    localparam int MEM_AW           = $clog2(MEM_WORDS); // Word address width
    localparam int RESET_CLK_CYCLES = 4;                 // Core reset hold after run
    localparam int RST_CNT_W        = $clog2(RESET_CLK_CYCLES + 1);

    // RV32I opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_BEQ   = 3'b000;
    localparam logic [2:0] F3_BNE   = 3'b001;
    localparam logic [2:0] F3_ECALL = 3'b000;

    // Core FSM states
    localparam logic [1:0] ST_FETCH = 2'd0;
    localparam logic [1:0] ST_EXEC  = 2'd1;
    localparam logic [1:0] ST_MEM   = 2'd2;
    localparam logic [1:0] ST_HALT  = 2'd3;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;    // Also imm[4:0] for I-type
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } sb;
    } instr_t;

endpackage

`default_nettype wire

// File: source/wb_bus_if.sv
`default_nettype none
`timescale 1ns/1ps

interface wb_bus_if;
    import processorci_pkg::*;

    logic            cyc;
    logic            stb;
    logic            we;    // Tied low on the instruction side
    logic [XLEN-1:0] addr;  // Byte address
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;
    logic            ack;

    modport master (
        output cyc, stb, we, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  cyc, stb, we, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

// File: source/wb_memory.sv
`default_nettype none
`timescale 1ns/1ps

module wb_memory (
    input  wire logic                               sys_clk,
    input  wire logic                               rst_n_i,
    wb_bus_if.slave                                 bus,
    input  wire logic                               host_we_i,
    input  wire logic [processorci_pkg::MEM_AW-1:0] host_addr_i,
    input  wire logic [processorci_pkg::XLEN-1:0]   host_wdata_i,
    output logic      [processorci_pkg::XLEN-1:0]   host_rdata_o
);
    import processorci_pkg::*;

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [MEM_AW-1:0] bus_idx;
    logic              req;
    logic              ack_q;
    logic [XLEN-1:0]   rdata_q;

    assign bus_idx = bus.addr[MEM_AW+1:2]; // Word index of byte address
    assign req     = bus.cyc & bus.stb & ~ack_q;

    // One ack per request, never back to back
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (req && bus.we) begin
            mem[bus_idx] <= bus.wdata; // Lands with the ack
        end else if (host_we_i) begin
            mem[host_addr_i] <= host_wdata_i;
        end
        rdata_q      <= mem[bus_idx];
        host_rdata_o <= mem[host_addr_i];
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q; // Valid in the ack cycle

endmodule

`default_nettype wire

// File: source/controller.sv
`default_nettype none
`timescale 1ns/1ps

module controller (
    input  wire logic                               sys_clk,
    input  wire logic                               rst_n_i,
    input  wire logic                               run_i,
    input  wire logic                               host_we_i,
    input  wire logic                               host_sel_i,   // 0 imem, 1 dmem
    input  wire logic [processorci_pkg::MEM_AW-1:0] host_addr_i,
    input  wire logic [processorci_pkg::XLEN-1:0]   host_wdata_i,
    output logic      [processorci_pkg::XLEN-1:0]   host_rdata_o,
    output logic                                    core_rst_n_o,
    wb_bus_if.slave                                 ibus,
    wb_bus_if.slave                                 dbus
);
    import processorci_pkg::*;

    logic [RST_CNT_W-1:0] rst_cnt_q;
    logic                 host_sel_q;
    logic                 imem_we;
    logic                 dmem_we;
    logic [XLEN-1:0]      imem_host_rdata;
    logic [XLEN-1:0]      dmem_host_rdata;

    // Reset sequencer, counts up while run is held
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i || !run_i) begin
            rst_cnt_q <= '0;
        end else if (rst_cnt_q != RST_CNT_W'(RESET_CLK_CYCLES)) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;
        end
    end

    assign core_rst_n_o = run_i & (rst_cnt_q == RST_CNT_W'(RESET_CLK_CYCLES));

    // Host writes only while the core is stopped
    assign imem_we = host_we_i & ~run_i & ~host_sel_i;
    assign dmem_we = host_we_i & ~run_i & host_sel_i;

    // Select follows the address by one cycle, like the read data
    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            host_sel_q <= 1'b0;
        end else begin
            host_sel_q <= host_sel_i;
        end
    end

    assign host_rdata_o = host_sel_q ? dmem_host_rdata : imem_host_rdata;

    wb_memory u_imem (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .bus          (ibus),
        .host_we_i    (imem_we),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (imem_host_rdata)
    );

    wb_memory u_dmem (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .bus          (dbus),
        .host_we_i    (dmem_we),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (dmem_host_rdata)
    );

endmodule

`default_nettype wire

// File: source/harv_lite.sv
`default_nettype none
`timescale 1ns/1ps

module harv_lite (
    input  wire logic sys_clk,
    input  wire logic rst_n_i,
    input  wire logic core_rst_n_i,
    wb_bus_if.master  ibus,
    wb_bus_if.master  dbus,
    output logic      halted_o
);
    import processorci_pkg::*;

    logic [1:0]      state_q;
    logic [XLEN-1:0] pc_q;
    instr_t          ir_q;
    logic [XLEN-1:0] regs [32];
    logic            ibus_cyc_q;
    logic            dbus_cyc_q;
    logic            dbus_we_q;
    logic [XLEN-1:0] dbus_addr_q;
    logic [XLEN-1:0] dbus_wdata_q;

    logic            run_en;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] mem_addr;
    logic            is_store;
    logic            is_mem;
    logic            is_halt;
    logic            rd_we;
    logic [XLEN-1:0] rd_wdata;

    // Either reset holds the core
    assign run_en = rst_n_i & core_rst_n_i;

    // Immediates from the R/I view
    assign imm_i = {{20{ir_q.ri.funct7[6]}}, ir_q.ri.funct7, ir_q.ri.rs2};
    assign imm_u = {ir_q.ri.funct7, ir_q.ri.rs2, ir_q.ri.rs1, ir_q.ri.funct3, 12'b0};
    assign imm_j = {{11{ir_q.ri.funct7[6]}}, ir_q.ri.funct7[6], ir_q.ri.rs1,
                    ir_q.ri.funct3, ir_q.ri.rs2[0], ir_q.ri.funct7[5:0],
                    ir_q.ri.rs2[4:1], 1'b0};

    // Immediates from the S/B view
    assign imm_s = {{20{ir_q.sb.imm_hi[6]}}, ir_q.sb.imm_hi, ir_q.sb.imm_lo};
    assign imm_b = {{19{ir_q.sb.imm_hi[6]}}, ir_q.sb.imm_hi[6], ir_q.sb.imm_lo[0],
                    ir_q.sb.imm_hi[5:0], ir_q.sb.imm_lo[4:1], 1'b0};

    // x0 reads as zero
    assign rs1_val = (ir_q.ri.rs1 == 5'd0) ? '0 : regs[ir_q.ri.rs1];
    assign rs2_val = (ir_q.sb.rs2 == 5'd0) ? '0 : regs[ir_q.sb.rs2];

    assign pc_plus4 = pc_q + 32'd4;
    assign is_store = (ir_q.sb.opcode == OPC_STORE);
    assign mem_addr = rs1_val + (is_store ? imm_s : imm_i);

    always_comb begin
        next_pc  = pc_plus4;
        rd_we    = 1'b0;
        rd_wdata = rs1_val + imm_i;
        is_mem   = 1'b0;
        is_halt  = 1'b0;
        if (state_q == ST_EXEC) begin
            case (ir_q.ri.opcode)
                OPC_LUI: begin
                    rd_we    = 1'b1;
                    rd_wdata = imm_u;
                end
                OPC_OPIMM: begin
                    rd_we = 1'b1; // ADDI
                end
                OPC_OP: begin
                    rd_we    = 1'b1;
                    rd_wdata = ir_q.ri.funct7[5] ? (rs1_val - rs2_val) : (rs1_val + rs2_val);
                end
                OPC_LOAD, OPC_STORE: begin
                    is_mem = 1'b1;
                end
                OPC_BRANCH: begin
                    if ((ir_q.sb.funct3 == F3_BEQ && rs1_val == rs2_val) ||
                        (ir_q.sb.funct3 == F3_BNE && rs1_val != rs2_val)) begin
                        next_pc = pc_q + imm_b;
                    end
                end
                OPC_JAL: begin
                    rd_we    = 1'b1;
                    rd_wdata = pc_plus4; // Link
                    next_pc  = pc_q + imm_j;
                end
                OPC_SYSTEM: begin
                    is_halt = (ir_q.ri.funct3 == F3_ECALL);
                end
                default: begin
                end
            endcase
        end else if (state_q == ST_MEM) begin
            rd_we    = dbus.ack & ~dbus_we_q; // Load writeback
            rd_wdata = dbus.rdata;
        end
    end

    // Control state
    always_ff @(posedge sys_clk) begin
        if (!run_en) begin
            state_q    <= ST_FETCH;
            pc_q       <= '0;
            ibus_cyc_q <= 1'b0;
            dbus_cyc_q <= 1'b0;
            dbus_we_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_FETCH: begin
                    ibus_cyc_q <= ~ibus.ack; // Raised on first cycle out of reset
                    if (ibus.ack) begin
                        state_q <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (is_halt) begin
                        state_q <= ST_HALT;
                    end else if (is_mem) begin
                        dbus_cyc_q <= 1'b1;
                        dbus_we_q  <= is_store;
                        state_q    <= ST_MEM;
                    end else begin
                        pc_q       <= next_pc;
                        ibus_cyc_q <= 1'b1;
                        state_q    <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (dbus.ack) begin
                        dbus_cyc_q <= 1'b0;
                        pc_q       <= pc_plus4;
                        ibus_cyc_q <= 1'b1;
                        state_q    <= ST_FETCH;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge sys_clk) begin
        if (state_q == ST_FETCH && ibus.ack) begin
            ir_q <= ibus.rdata;
        end
        if (state_q == ST_EXEC && is_mem) begin
            dbus_addr_q  <= mem_addr;
            dbus_wdata_q <= rs2_val;
        end
        if (rd_we && ir_q.ri.rd != 5'd0) begin
            regs[ir_q.ri.rd] <= rd_wdata;
        end
    end

    assign ibus.cyc   = ibus_cyc_q;
    assign ibus.stb   = ibus_cyc_q;
    assign ibus.we    = 1'b0;
    assign ibus.addr  = pc_q;
    assign ibus.wdata = '0;

    assign dbus.cyc   = dbus_cyc_q;
    assign dbus.stb   = dbus_cyc_q;
    assign dbus.we    = dbus_we_q;
    assign dbus.addr  = dbus_addr_q;
    assign dbus.wdata = dbus_wdata_q;

    assign halted_o = (state_q == ST_HALT);

endmodule

`default_nettype wire

// File: source/processorci_top.sv
`default_nettype none
`timescale 1ns/1ps

module processorci_top (
    input  wire logic                               sys_clk,
    input  wire logic                               rst_n_i,
    input  wire logic                               run_i,
    input  wire logic                               host_we_i,
    input  wire logic                               host_sel_i,
    input  wire logic [processorci_pkg::MEM_AW-1:0] host_addr_i,
    input  wire logic [processorci_pkg::XLEN-1:0]   host_wdata_i,
    output logic      [processorci_pkg::XLEN-1:0]   host_rdata_o,
    output logic                                    halted_o
);

    logic core_rst_n; // From the reset sequencer

    wb_bus_if ibus ();
    wb_bus_if dbus ();

    controller u_controller (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .host_we_i    (host_we_i),
        .host_sel_i   (host_sel_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_rdata_o (host_rdata_o),
        .core_rst_n_o (core_rst_n),
        .ibus         (ibus),
        .dbus         (dbus)
    );

    // Core space
    harv_lite u_core (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .core_rst_n_i (core_rst_n),
        .ibus         (ibus),
        .dbus         (dbus),
        .halted_o     (halted_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o; // 10 ns period
    end

    // Low for three rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/processorci_checker.sv
`default_nettype none
`timescale 1ns/1ps

module processorci_checker (
    input wire logic sys_clk,
    input wire logic rst_n_i,
    input wire logic core_rst_n_i,
    input wire logic ibus_cyc_i,
    input wire logic ibus_stb_i,
    input wire logic ibus_ack_i,
    input wire logic dbus_cyc_i,
    input wire logic dbus_stb_i,
    input wire logic dbus_ack_i,
    input wire logic halted_i
);

    int fail_count = 0; // Failed assertions so far

    // Strobe always follows cycle
    ibus_stb_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        ibus_stb_i == ibus_cyc_i)
        else begin
            fail_count++;
            $error("ibus stb differs from cyc");
        end
    dbus_stb_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        dbus_stb_i == dbus_cyc_i)
        else begin
            fail_count++;
            $error("dbus stb differs from cyc");
        end

    // One ack per access
    ibus_ack_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        ibus_ack_i |=> !ibus_ack_i)
        else begin
            fail_count++;
            $error("ibus ack high two cycles in a row");
        end
    dbus_ack_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        dbus_ack_i |=> !dbus_ack_i)
        else begin
            fail_count++;
            $error("dbus ack high two cycles in a row");
        end

    dbus_rst_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !core_rst_n_i |-> !dbus_cyc_i)
        else begin
            fail_count++;
            $error("dbus cycle while the core is held in reset");
        end

    // Sticky until the core reset
    halt_a: assert property (@(posedge sys_clk) disable iff (!rst_n_i || !core_rst_n_i)
        halted_i |=> halted_i)
        else begin
            fail_count++;
            $error("halted dropped without a reset");
        end

endmodule

bind harv_lite processorci_checker u_checker (
    .sys_clk      (sys_clk),
    .rst_n_i      (rst_n_i),
    .core_rst_n_i (core_rst_n_i),
    .ibus_cyc_i   (ibus.cyc),
    .ibus_stb_i   (ibus.stb),
    .ibus_ack_i   (ibus.ack),
    .dbus_cyc_i   (dbus.cyc),
    .dbus_stb_i   (dbus.stb),
    .dbus_ack_i   (dbus.ack),
    .halted_i     (halted_o)
);

`default_nettype wire

// File: dv/processorci_tb.sv
`default_nettype none
`timescale 1ns/1ps

module processorci_tb;
    import processorci_pkg::*;

    localparam logic [31:0] LCG_SEED = 32'h63e4;

    logic              sys_clk;
    logic              rst_n;
    logic              run;
    logic              host_we;
    logic              host_sel;
    logic [MEM_AW-1:0] host_addr;
    logic [XLEN-1:0]   host_wdata;
    logic [XLEN-1:0]   host_rdata;
    logic              halted;

    logic [31:0] tdata [0:63];  // Header, program, expected pairs
    logic [31:0] dwords [0:7];
    logic [31:0] lcg_state;
    logic [31:0] sum;
    int          prog_len;
    int          n_pairs;
    int          limit;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    tb_clock_gen u_clk (
        .clk_o   (sys_clk),
        .rst_n_o (rst_n)
    );

    processorci_top dut (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n),
        .run_i        (run),
        .host_we_i    (host_we),
        .host_sel_i   (host_sel),
        .host_addr_i  (host_addr),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .halted_o     (halted)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("FAILED at %0t ns: %s expected %08h got %08h", $time, name, exp, act);
    endtask

    task automatic host_write(input logic sel, input int addr, input logic [31:0] data);
        @(negedge sys_clk);
        host_we    = 1'b1;
        host_sel   = sel;
        host_addr  = addr[MEM_AW-1:0];
        host_wdata = data;
        @(negedge sys_clk);
        host_we    = 1'b0;
    endtask

    // Read word shows one cycle after the address
    task automatic read_expect(input logic sel, input int addr, input logic [31:0] exp);
        @(negedge sys_clk);
        host_we   = 1'b0;
        host_sel  = sel;
        host_addr = addr[MEM_AW-1:0];
        @(negedge sys_clk);
        checks++;
        if (host_rdata !== exp) begin
            report_mismatch($sformatf("host_rdata_o %s[%0d]", sel ? "dmem" : "imem", addr),
                            exp, host_rdata);
        end
    endtask

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run not finished after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        run        = 1'b0;
        host_we    = 1'b0;
        host_sel   = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        $readmemh("dv/processorci_testdata.txt", tdata);
        prog_len = int'(tdata[0]);
        n_pairs  = int'(tdata[1]);
        limit    = 8 * (prog_len * 5) + 100;

        // Data words and their reference sum
        lcg_state = LCG_SEED;
        sum       = '0;
        for (int i = 0; i < 8; i++) begin
            lcg_state = lcg_next(lcg_state);
            dwords[i] = lcg_state;
            sum       = sum + lcg_state;
        end

        @(posedge rst_n);
        @(negedge sys_clk);
        checks++;
        if (halted !== 1'b0) report_mismatch("halted_o", 32'd0, {31'd0, halted});

        for (int i = 0; i < prog_len; i++) host_write(1'b0, i, tdata[2 + i]);
        for (int i = 0; i < 8; i++) host_write(1'b1, i, dwords[i]);
        for (int i = 16; i < 25; i++) host_write(1'b1, i, 32'd0); // Result area

        for (int i = 0; i < prog_len; i++) read_expect(1'b0, i, tdata[2 + i]);
        for (int i = 0; i < 8; i++) read_expect(1'b1, i, dwords[i]);
        for (int i = 16; i < 25; i++) read_expect(1'b1, i, 32'd0);
        checks++;
        if (halted !== 1'b0) report_mismatch("halted_o", 32'd0, {31'd0, halted});

        @(negedge sys_clk);
        run = 1'b1;
        while (halted !== 1'b1) @(negedge sys_clk);

        // Host writes while running must not land
        host_write(1'b1, 19, 32'hbad0_0019);
        host_write(1'b0, 0, 32'hbad0_0000);
        @(negedge sys_clk);
        run = 1'b0;

        read_expect(1'b1, 16, sum);
        read_expect(1'b1, 17, dwords[0]);
        checks++;
        if (halted !== 1'b0) report_mismatch("halted_o", 32'd0, {31'd0, halted});
        for (int i = 0; i < n_pairs; i++) begin
            read_expect(1'b1, int'(tdata[2 + prog_len + 2 * i]), tdata[3 + prog_len + 2 * i]);
        end
        read_expect(1'b0, 0, tdata[2]);
        for (int i = 0; i < 8; i++) read_expect(1'b1, i, dwords[i]);

        $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d cycles",
                 checks, errors, dut.u_core.u_checker.fail_count, cycles);
        if (errors == 0 && dut.u_core.u_checker.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/processorci_testdata.txt
// Header: program length, expected pair count. Then program words, imem order.
// Last: expected pairs, one per line: dmem word address, value
1c 7
// Init pointer, sum, count, iterations; loop at word 4
00000093 00000113 00800193 00000293
0000a203 00410133 00408093 fff18193
// Iteration count, BNE back, store sum, copy word 0
00128293 fe0196e3 04202023 00002303
04602223 04502423 008003ef 04502623
// LUI plus ADDI constants, JAL link, BEQ skip, SUB
12345437 67840413 04802823 abcdf4b7
def48493 04902a23 04702c23 00018463
04802e23 40940533 06a02023 00000073
12 00000008
13 00000000
14 12345678
15 abcdedef
16 0000003c
17 00000000
18 66666889

// File: list.f
source/processorci_pkg.sv
source/wb_bus_if.sv
source/wb_memory.sv
source/controller.sv
source/harv_lite.sv
source/processorci_top.sv
dv/tb_clock_gen.sv
dv/processorci_checker.sv
dv/processorci_tb.sv

// File: Bender.yml
package:
  name: processorci

sources:
  - files:
      - source/processorci_pkg.sv
      - source/wb_bus_if.sv
      - source/wb_memory.sv
      - source/controller.sv
      - source/harv_lite.sv
      - source/processorci_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/processorci_checker.sv
      - dv/processorci_tb.sv
